// ==== source/i3c_timing_pkg.sv ====
// Bus-condition constants: threshold width, quiet counter width, bus condition encoding
package i3c_timing_pkg;

  // Threshold inputs, counted in clk_i cycles
  localparam int unsigned T_WIDTH = 20;

  // Quiet-time counter, wide enough that it never wraps before idle
  localparam int unsigned CNT_WIDTH = 32;

  // Zero-extension pad for threshold compares
  localparam int unsigned PAD_WIDTH = CNT_WIDTH - T_WIDTH;

  // Encoded bus condition, ordered by quiet time
  typedef enum logic [1:0] {
    BUS_BUSY  = 2'd0,  // Activity or too short a quiet period
    BUS_FREE  = 2'd1,  // Quiet for at least t_BUF
    BUS_AVAIL = 2'd2,  // Quiet for at least t_AVAL
    BUS_IDLE  = 2'd3   // Quiet for at least t_IDLE
  } bus_cond_e;

endpackage : i3c_timing_pkg

// ==== source/i3c_arb_pkg.sv ====
// Bus-access constants: requester count, requester indices, arbiter state encoding
package i3c_arb_pkg;

  // Peer requesters sharing the bus
  localparam int unsigned NUM_REQ = 2;

  // Bit positions in the request and grant vectors
  localparam int unsigned REQ_XFER = 0;  // Private-transfer engine
  localparam int unsigned REQ_HJ   = 1;  // Hot-join / in-band engine

  // Ownership of the bus
  typedef enum logic [1:0] {
    ARB_IDLE     = 2'd0,  // Nobody owns the bus
    ARB_OWN_XFER = 2'd1,  // Private-transfer engine holds the bus
    ARB_OWN_HJ   = 2'd2   // Hot-join engine holds the bus
  } arb_state_e;

endpackage : i3c_arb_pkg

// ==== source/bus_monitor.sv ====
// Line sampler with START, STOP and edge detection and transaction-active tracking
`timescale 1ns/1ps

module bus_monitor (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic scl_i,          // Sampled SCL level
  input  logic sda_i,          // Sampled SDA level
  output logic line_edge_o,    // Any line changed between stages
  output logic start_det_o,    // SDA fall with SCL high
  output logic stop_det_o,     // SDA rise with SCL high
  output logic xfer_active_o   // Between START and STOP
);

  logic scl_s1, scl_s2;  // Newer and older SCL samples
  logic sda_s1, sda_s2;  // Newer and older SDA samples
  logic xfer_active_q;
  logic scl_high;

  // Two sample stages, reset to the released line level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_s1 <= 1'b1;
      scl_s2 <= 1'b1;
      sda_s1 <= 1'b1;
      sda_s2 <= 1'b1;
    end else begin
      scl_s1 <= scl_i;   // First stage
      scl_s2 <= scl_s1;  // Second stage
      sda_s1 <= sda_i;
      sda_s2 <= sda_s1;
    end
  end

  // SCL stable high across both stages
  assign scl_high = scl_s1 & scl_s2;

  // Either line differs between stages
  assign line_edge_o = (scl_s1 ^ scl_s2) | (sda_s1 ^ sda_s2);

  // START is SDA going low while SCL stays high
  assign start_det_o = scl_high & sda_s2 & ~sda_s1;

  // STOP is SDA going high while SCL stays high
  assign stop_det_o = scl_high & ~sda_s2 & sda_s1;

  // Transaction in progress from START until STOP
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      xfer_active_q <= 1'b0;
    end else if (start_det_o) begin
      xfer_active_q <= 1'b1;  // Repeated START keeps it set
    end else if (stop_det_o) begin
      xfer_active_q <= 1'b0;
    end
  end

  assign xfer_active_o = xfer_active_q;

  // START and STOP need opposite SDA directions
  a_start_stop_excl : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(start_det_o && stop_det_o)
  ) else $error("START and STOP detected in the same cycle");

endmodule : bus_monitor

// ==== source/bus_timers.sv ====
// Quiet-time counter with free, available and idle threshold compares
`timescale 1ns/1ps

module bus_timers (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           enable_i,           // Count quiet cycles
  input  logic                           restart_counter_i,  // Line activity seen
  input  logic [i3c_timing_pkg::T_WIDTH-1:0] t_bus_free_i,   // t_BUF in cycles
  input  logic [i3c_timing_pkg::T_WIDTH-1:0] t_bus_avail_i,  // t_AVAL in cycles
  input  logic [i3c_timing_pkg::T_WIDTH-1:0] t_bus_idle_i,   // t_IDLE in cycles
  output logic                           bus_busy_o,
  output logic                           bus_free_o,
  output logic                           bus_avail_o,
  output logic                           bus_idle_o
);

  import i3c_timing_pkg::*;

  logic [CNT_WIDTH-1:0] quiet_cnt_q;  // Cycles since last activity
  logic                 enable_q;     // Registered count enable

  // Enable stops once idle so the counter cannot wrap
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q <= 1'b0;
    end else begin
      enable_q <= enable_i & ~bus_idle_o;
    end
  end

  // Available counts from the start of the free period as well
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      quiet_cnt_q <= '0;
    end else if (restart_counter_i) begin
      quiet_cnt_q <= '0;  // Activity restarts the quiet period
    end else if (enable_q) begin
      quiet_cnt_q <= quiet_cnt_q + 1'b1;
    end
  end

  // Thresholds zero-extended to counter width
  assign bus_free_o  = quiet_cnt_q >= {{PAD_WIDTH{1'b0}}, t_bus_free_i};
  assign bus_avail_o = quiet_cnt_q >= {{PAD_WIDTH{1'b0}}, t_bus_avail_i};
  assign bus_idle_o  = quiet_cnt_q >= {{PAD_WIDTH{1'b0}}, t_bus_idle_i};

  // Busy when no quiet condition holds
  assign bus_busy_o = ~(bus_free_o | bus_avail_o | bus_idle_o);

  a_busy_excl : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    bus_busy_o == !(bus_free_o || bus_avail_o || bus_idle_o)
  ) else $error("Busy does not match the other bus conditions");

endmodule : bus_timers

// ==== source/bus_access_arbiter.sv ====
// Round-robin bus arbiter for two peers with per-peer bus condition gating
`timescale 1ns/1ps

module bus_access_arbiter (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [i3c_arb_pkg::NUM_REQ-1:0] req_i,        // Request levels
  input  logic                             bus_avail_i,  // Gate for XFER
  input  logic                             bus_idle_i,   // Gate for HJ
  output logic [i3c_arb_pkg::NUM_REQ-1:0] gnt_o         // Grant levels, one-hot
);

  import i3c_arb_pkg::*;

  arb_state_e state_q, state_d;
  logic       last_hj_q, last_hj_d;  // HJ owned the bus last
  logic       elig_xfer;
  logic       elig_hj;

  // Each peer needs its own bus condition
  assign elig_xfer = req_i[REQ_XFER] & bus_avail_i;
  assign elig_hj   = req_i[REQ_HJ] & bus_idle_i;

  always_comb begin
    state_d   = state_q;
    last_hj_d = last_hj_q;
    unique case (state_q)
      ARB_IDLE: begin
        if (elig_xfer && elig_hj) begin
          // Both ready, give it to the one that waited
          if (last_hj_q) begin
            state_d   = ARB_OWN_XFER;
            last_hj_d = 1'b0;
          end else begin
            state_d   = ARB_OWN_HJ;
            last_hj_d = 1'b1;
          end
        end else if (elig_xfer) begin
          state_d   = ARB_OWN_XFER;
          last_hj_d = 1'b0;
        end else if (elig_hj) begin
          state_d   = ARB_OWN_HJ;
          last_hj_d = 1'b1;
        end
      end
      ARB_OWN_XFER: begin
        if (!req_i[REQ_XFER]) begin
          state_d = ARB_IDLE;  // Held regardless of bus condition
        end
      end
      ARB_OWN_HJ: begin
        if (!req_i[REQ_HJ]) begin
          state_d = ARB_IDLE;
        end
      end
      default: begin
        state_d = ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= ARB_IDLE;
      last_hj_q <= 1'b1;  // XFER wins the first tie
    end else begin
      state_q   <= state_d;
      last_hj_q <= last_hj_d;
    end
  end

  // Grants decoded straight from the owner state
  assign gnt_o[REQ_XFER] = (state_q == ARB_OWN_XFER);
  assign gnt_o[REQ_HJ]   = (state_q == ARB_OWN_HJ);

  a_gnt_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $onehot0(gnt_o)
  ) else $error("More than one grant active");

  // A grant rises only after its peer was eligible
  a_xfer_gated : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(gnt_o[REQ_XFER]) |-> $past(req_i[REQ_XFER] && bus_avail_i)
  ) else $error("XFER granted without bus available");

  a_hj_gated : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $rose(gnt_o[REQ_HJ]) |-> $past(req_i[REQ_HJ] && bus_idle_i)
  ) else $error("HJ granted without bus idle");

endmodule : bus_access_arbiter

// ==== source/i3c_bus_ctrl_top.sv ====
// Top level joining the bus monitor, bus timers and bus access arbiter
`timescale 1ns/1ps

module i3c_bus_ctrl_top (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               scl_i,
  input  logic                               sda_i,
  input  logic [i3c_timing_pkg::T_WIDTH-1:0] t_bus_free_i,
  input  logic [i3c_timing_pkg::T_WIDTH-1:0] t_bus_avail_i,
  input  logic [i3c_timing_pkg::T_WIDTH-1:0] t_bus_idle_i,
  input  logic                               timers_en_i,  // Software timer enable
  input  logic                               req_xfer_i,   // Private-transfer request
  input  logic                               req_hj_i,     // Hot-join request
  output logic                               start_det_o,
  output logic                               stop_det_o,
  output i3c_timing_pkg::bus_cond_e          bus_cond_o,
  output logic                               gnt_xfer_o,
  output logic                               gnt_hj_o
);

  import i3c_timing_pkg::*;
  import i3c_arb_pkg::*;

  logic               line_edge;
  logic               xfer_active;
  logic               timers_en;
  logic               bus_busy, bus_free, bus_avail, bus_idle;
  logic [NUM_REQ-1:0] req;
  logic [NUM_REQ-1:0] gnt;

  bus_monitor i_monitor (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .scl_i         (scl_i),
    .sda_i         (sda_i),
    .line_edge_o   (line_edge),
    .start_det_o   (start_det_o),
    .stop_det_o    (stop_det_o),
    .xfer_active_o (xfer_active)
  );

  // No quiet counting inside a transaction
  assign timers_en = timers_en_i & ~xfer_active;

  bus_timers i_timers (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .enable_i          (timers_en),
    .restart_counter_i (line_edge),  // Any edge restarts the quiet period
    .t_bus_free_i      (t_bus_free_i),
    .t_bus_avail_i     (t_bus_avail_i),
    .t_bus_idle_i      (t_bus_idle_i),
    .bus_busy_o        (bus_busy),
    .bus_free_o        (bus_free),
    .bus_avail_o       (bus_avail),
    .bus_idle_o        (bus_idle)
  );

  // Busy excludes the rest, then longest quiet wins
  always_comb begin
    if (bus_busy) begin
      bus_cond_o = BUS_BUSY;
    end else if (bus_idle) begin
      bus_cond_o = BUS_IDLE;
    end else if (bus_avail) begin
      bus_cond_o = BUS_AVAIL;
    end else begin
      bus_cond_o = BUS_FREE;
    end
  end

  assign req[REQ_XFER] = req_xfer_i;
  assign req[REQ_HJ]   = req_hj_i;

  bus_access_arbiter i_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req),
    .bus_avail_i (bus_avail),
    .bus_idle_i  (bus_idle),
    .gnt_o       (gnt)
  );

  assign gnt_xfer_o = gnt[REQ_XFER];
  assign gnt_hj_o   = gnt[REQ_HJ];

endmodule : i3c_bus_ctrl_top

// ==== tb/tb_model.svh ====
// Reference model of line sampler, quiet timers and arbiter, plus the LCG random source
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

int unsigned          lcg_state = 32'd54;  // Fixed seed
logic                 m_scl_s1, m_scl_s2;  // Model SCL stages
logic                 m_sda_s1, m_sda_s2;  // Model SDA stages
logic                 m_active;            // START seen, STOP not yet
logic                 m_en_q;              // Count enable, one cycle late
logic [CNT_WIDTH-1:0] m_cnt;               // Quiet cycles
arb_state_e           m_state;             // Current bus owner
logic                 m_last_hj;           // HJ owned last

function automatic int unsigned lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state >> 8;  // Low bits have a short period
endfunction

function automatic int unsigned draw_range(input int unsigned lo, input int unsigned hi);
  return lo + lcg_next() % (hi - lo + 1);
endfunction

function automatic logic coin_flip();
  return (lcg_next() & 32'd1) == 32'd1;
endfunction

function automatic logic count_reached(input logic [T_WIDTH-1:0] thr);
  return m_cnt >= CNT_WIDTH'(thr);  // Threshold zero-extended
endfunction

function automatic logic edge_pending();
  return (m_scl_s1 != m_scl_s2) || (m_sda_s1 != m_sda_s2);
endfunction

function automatic logic start_pulse();
  return m_scl_s1 && m_scl_s2 && m_sda_s2 && !m_sda_s1;  // SDA falls, SCL high
endfunction

function automatic logic stop_pulse();
  return m_scl_s1 && m_scl_s2 && !m_sda_s2 && m_sda_s1;  // SDA rises, SCL high
endfunction

// Longest quiet threshold reached wins
function automatic bus_cond_e cond_from_count();
  if (count_reached(t_bus_idle_i)) return BUS_IDLE;
  if (count_reached(t_bus_avail_i)) return BUS_AVAIL;
  if (count_reached(t_bus_free_i)) return BUS_FREE;
  return BUS_BUSY;
endfunction

task automatic reset_model();
  m_scl_s1  = 1'b1;  // Released lines
  m_scl_s2  = 1'b1;
  m_sda_s1  = 1'b1;
  m_sda_s2  = 1'b1;
  m_active  = 1'b0;
  m_en_q    = 1'b0;
  m_cnt     = '0;
  m_state   = ARB_IDLE;
  m_last_hj = 1'b1;  // XFER wins the first tie
endtask

// One clock edge, all next values from the current state
task automatic advance_model();
  logic start_now, stop_now, chg_now, idle_now, elig_x, elig_h;
  start_now = start_pulse();
  stop_now  = stop_pulse();
  chg_now   = edge_pending();
  idle_now  = count_reached(t_bus_idle_i);
  elig_x    = req_xfer_i && count_reached(t_bus_avail_i);
  elig_h    = req_hj_i && idle_now;
  case (m_state)
    ARB_IDLE: begin
      if (elig_x && (!elig_h || m_last_hj)) begin
        m_state   = ARB_OWN_XFER;
        m_last_hj = 1'b0;
      end else if (elig_h) begin
        m_state   = ARB_OWN_HJ;
        m_last_hj = 1'b1;
      end
    end
    ARB_OWN_XFER: if (!req_xfer_i) m_state = ARB_IDLE;  // Held until req drops
    ARB_OWN_HJ: if (!req_hj_i) m_state = ARB_IDLE;
    default: m_state = ARB_IDLE;
  endcase
  if (chg_now) m_cnt = '0;
  else if (m_en_q) m_cnt = m_cnt + CNT_WIDTH'(1);
  m_en_q = timers_en_i && !m_active && !idle_now;  // Frozen at idle
  if (start_now) m_active = 1'b1;
  else if (stop_now) m_active = 1'b0;
  m_scl_s2 = m_scl_s1;
  m_scl_s1 = scl_i;
  m_sda_s2 = m_sda_s1;
  m_sda_s1 = sda_i;
endtask

`endif

// ==== tb/tb_i3c_bus_ctrl.sv ====
// Testbench for the I3C bus front end: clock, reset, LCG stimulus, model checks, watchdog
`timescale 1ns/1ps

module tb_i3c_bus_ctrl;
  import i3c_timing_pkg::*;
  import i3c_arb_pkg::*;

  localparam int unsigned CLK_PERIOD    = 4;
  localparam int unsigned BUDGET_CYCLES = 10 + 300 + 300 + 800 + 400 + 600;  // Reset plus tests
  localparam int unsigned MARGIN_CYCLES = 200;

  logic               clk_i, rst_ni, scl_i, sda_i, timers_en_i, req_xfer_i, req_hj_i;
  logic [T_WIDTH-1:0] t_bus_free_i, t_bus_avail_i, t_bus_idle_i;
  logic               start_det_o, stop_det_o, gnt_xfer_o, gnt_hj_o;
  bus_cond_e          bus_cond_o;
  int unsigned        err_cnt = 0, check_cnt = 0, err_base = 0;
  int unsigned        starts_sent = 0, stops_sent = 0, starts_seen = 0, stops_seen = 0;

  `include "tb_model.svh"

  i3c_bus_ctrl_top i_dut (
    .clk_i (clk_i), .rst_ni (rst_ni), .scl_i (scl_i), .sda_i (sda_i),
    .t_bus_free_i (t_bus_free_i), .t_bus_avail_i (t_bus_avail_i),
    .t_bus_idle_i (t_bus_idle_i), .timers_en_i (timers_en_i),
    .req_xfer_i (req_xfer_i), .req_hj_i (req_hj_i),
    .start_det_o (start_det_o), .stop_det_o (stop_det_o), .bus_cond_o (bus_cond_o),
    .gnt_xfer_o (gnt_xfer_o), .gnt_hj_o (gnt_hj_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #((BUDGET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the tests did not finish within their cycle budget");
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic compare_bit(input string name, input logic exp, input logic act);
    check_cnt++;
    assert (exp === act) else begin
      $display("[ERROR] %0d ns: %s expected %b got %b", $time, name, exp, act);
      err_cnt++;
    end
  endtask

  task automatic compare_cond(input bus_cond_e exp, input bus_cond_e act);
    check_cnt++;
    assert (exp === act) else begin
      $display("[ERROR] %0d ns: bus_cond_o expected %s got %s", $time, exp.name(), act.name());
      err_cnt++;
    end
  endtask

  task automatic require(input logic ok, input string what);
    check_cnt++;
    assert (ok) else begin
      $display("At %0d ns: %s", $time, what);
      err_cnt++;
    end
  endtask

  // Outputs settle between edges, inputs hold until the next rising edge
  always @(negedge clk_i) begin
    if (!rst_ni) begin
      reset_model();
    end else begin
      compare_bit("start_det_o", start_pulse(), start_det_o);
      compare_bit("stop_det_o", stop_pulse(), stop_det_o);
      compare_cond(cond_from_count(), bus_cond_o);
      compare_bit("gnt_xfer_o", m_state == ARB_OWN_XFER, gnt_xfer_o);
      compare_bit("gnt_hj_o", m_state == ARB_OWN_HJ, gnt_hj_o);
      require(!(gnt_xfer_o && gnt_hj_o), "both grants are high together");
      if (start_det_o) starts_seen++;
      if (stop_det_o) stops_seen++;
      advance_model();
    end
  end

  task automatic skip_cycles(input int unsigned n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic pulse_scl();
    @(posedge clk_i) scl_i <= 1'b0;
    @(posedge clk_i) scl_i <= 1'b1;
  endtask

  task automatic flip_sda();  // Changes SDA only while SCL is low
    @(posedge clk_i) scl_i <= 1'b0;
    @(posedge clk_i) sda_i <= ~sda_i;
    @(posedge clk_i) scl_i <= 1'b1;
  endtask

  task automatic pick_thresholds();
    int unsigned fr, av, id;
    fr = draw_range(4, 12);
    av = fr + draw_range(2, 12);   // Ascending free, avail, idle
    id = av + draw_range(4, 20);
    @(posedge clk_i);
    t_bus_free_i  <= T_WIDTH'(fr);
    t_bus_avail_i <= T_WIDTH'(av);
    t_bus_idle_i  <= T_WIDTH'(id);
  endtask

  function automatic logic grant_of(input int unsigned sel);
    if (sel == 0) return gnt_xfer_o;
    if (sel == 1) return gnt_hj_o;
    return gnt_xfer_o | gnt_hj_o;  // Either peer
  endfunction

  task automatic await_grant(input int unsigned sel, input logic level, input int unsigned limit);
    int unsigned n;
    n = 0;
    @(negedge clk_i);
    while (grant_of(sel) !== level && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    require(grant_of(sel) === level, "grant did not reach the expected level in time");
  endtask

  task automatic hold_until_idle();
    int unsigned n;
    n = 0;
    skip_cycles(2);  // Counter clear lands two edges after the toggle
    @(negedge clk_i);
    while (bus_cond_o != BUS_IDLE && n < 80) begin
      @(negedge clk_i);
      n++;
    end
    require(bus_cond_o == BUS_IDLE, "bus never became idle after a quiet period");
  endtask

  task automatic report_test(input int unsigned id, input string name);
    $display("Test %0d %s finished with %0d errors", id, name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  task automatic detect_start_stop();
    repeat (8) begin
      skip_cycles(draw_range(2, 6));
      @(posedge clk_i) sda_i <= 1'b0;  // START
      starts_sent++;
      skip_cycles(2);
      repeat (draw_range(2, 5)) begin
        @(posedge clk_i) scl_i <= 1'b0;
        @(posedge clk_i) sda_i <= coin_flip();
        @(posedge clk_i) scl_i <= 1'b1;
      end
      @(posedge clk_i);
      scl_i <= 1'b0;
      sda_i <= 1'b0;
      @(posedge clk_i) scl_i <= 1'b1;
      @(posedge clk_i);
      @(posedge clk_i) sda_i <= 1'b1;  // STOP
      stops_sent++;
      skip_cycles(3);
    end
    skip_cycles(4);
    check_cnt += 2;
    assert (starts_seen == starts_sent) else begin
      $display("[ERROR] %0d ns: start_det_o pulses expected %0d got %0d",
               $time, starts_sent, starts_seen);
      err_cnt++;
    end
    assert (stops_seen == stops_sent) else begin
      $display("[ERROR] %0d ns: stop_det_o pulses expected %0d got %0d",
               $time, stops_sent, stops_seen);
      err_cnt++;
    end
  endtask

  task automatic progress_conditions();
    repeat (4) begin
      pick_thresholds();
      pulse_scl();        // Restart the quiet period
      hold_until_idle();  // Model checks each step cycle by cycle
    end
  endtask

  task automatic restart_on_edges();
    bus_cond_e frozen;
    repeat (6) begin
      skip_cycles(draw_range(0, 50));
      if (coin_flip()) pulse_scl();
      else flip_sda();
      repeat (2) @(negedge clk_i);  // Counter cleared by the second edge after the toggle
      require(bus_cond_o == BUS_BUSY, "line toggle did not return the bus to busy");
      skip_cycles(draw_range(2, 30));
      @(posedge clk_i) timers_en_i <= 1'b0;
      repeat (2) @(negedge clk_i);  // Registered enable lets one count through
      frozen = bus_cond_o;
      repeat (draw_range(5, 20)) begin
        @(negedge clk_i);
        require(bus_cond_o == frozen, "condition moved while the timers were disabled");
      end
      @(posedge clk_i) timers_en_i <= 1'b1;
    end
    if (!sda_i) flip_sda();  // Leave the lines released
  endtask

  task automatic gate_grants();
    for (int unsigned r = 0; r < 4; r++) begin
      pick_thresholds();
      pulse_scl();
      skip_cycles(2);
      @(posedge clk_i);
      if (r % 2 == 0) req_xfer_i <= 1'b1;
      else req_hj_i <= 1'b1;
      await_grant(r % 2, 1'b1, 100);
      if (r % 2 == 0) require(bus_cond_o >= BUS_AVAIL, "XFER granted before AVAIL");
      else require(bus_cond_o == BUS_IDLE, "HJ granted before IDLE");
      skip_cycles(draw_range(2, 10));
      pulse_scl();  // Grant holds through bus activity
      @(posedge clk_i);
      req_xfer_i <= 1'b0;
      req_hj_i   <= 1'b0;
      await_grant(r % 2, 1'b0, 5);
    end
  endtask

  task automatic rotate_ownership();
    logic prev_hj;
    prev_hj = 1'b0;
    for (int unsigned r = 0; r < 6; r++) begin
      pulse_scl();
      hold_until_idle();
      @(posedge clk_i);
      req_xfer_i <= 1'b1;
      req_hj_i   <= 1'b1;
      await_grant(2, 1'b1, 5);
      if (r > 0) require(gnt_hj_o != prev_hj, "bus ownership did not alternate");
      prev_hj = gnt_hj_o;
      repeat (draw_range(1, 3)) begin
        pulse_scl();
        skip_cycles(draw_range(1, 5));
      end
      @(posedge clk_i);
      req_xfer_i <= 1'b0;
      req_hj_i   <= 1'b0;
      await_grant(2, 1'b0, 5);
    end
  endtask

  initial begin
    rst_ni        = 1'b0;
    scl_i         = 1'b1;  // Released lines
    sda_i         = 1'b1;
    timers_en_i   = 1'b1;
    req_xfer_i    = 1'b0;
    req_hj_i      = 1'b0;
    t_bus_free_i  = T_WIDTH'(8);
    t_bus_avail_i = T_WIDTH'(16);
    t_bus_idle_i  = T_WIDTH'(32);
    skip_cycles(5);
    rst_ni <= 1'b1;
    skip_cycles(2);
    detect_start_stop();
    report_test(1, "start/stop detection");
    progress_conditions();
    report_test(2, "condition progression");
    restart_on_edges();
    report_test(3, "edge restart and freeze");
    gate_grants();
    report_test(4, "grant gating");
    rotate_ownership();
    report_test(5, "round-robin and hold");
    $display("Tests run: 5, checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule : tb_i3c_bus_ctrl

// ==== files.f ====
+incdir+tb
source/i3c_timing_pkg.sv
source/i3c_arb_pkg.sv
source/bus_monitor.sv
source/bus_timers.sv
source/bus_access_arbiter.sv
source/i3c_bus_ctrl_top.sv
tb/tb_i3c_bus_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the I3C bus front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
  -f files.f --top-module tb_i3c_bus_ctrl --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_i3c_bus_ctrl" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "PASS: all tests" "$LOG_FILE"; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi
